// File: project.f
logic/mbus_bus_pkg.sv
logic/mbus_power_pkg.sv
logic/mbus_ctrl.sv
logic/mbus_power_seq.sv
logic/mbus_node.sv
logic/mbus_ctrl_wrapper.sv
dv/mbus_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mbus_tb
FILELIST = project.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/mbus_tb.sv
`timescale 1ns/10ps

module mbus_tb;

	localparam int N_ENTRY      = 8;
	localparam int ACK_DELAY    = 3;                      // Layer answers RX_REQ late.
	localparam int ACK_LIMIT    = 40;                     // Cycles allowed for TX_ACK.
	localparam int DONE_LIMIT   = 2000;                   // Frame plus watchdog margin.
	localparam int RX_LIMIT     = 40;
	localparam int PWR_LIMIT    = 50;
	localparam int STALL_CYCLES = 30;                     // Back-pressure window.

	logic        CLK_EXT = 1'b0;
	logic        RESETn_local;
	logic        DIN, DOUT, CLKOUT;
	logic [mbus_bus_pkg::ADDR_WIDTH-1:0]      TX_ADDR, RX_ADDR;
	logic [mbus_bus_pkg::DATA_WIDTH-1:0]      TX_DATA, RX_DATA;
	logic [mbus_bus_pkg::WATCH_DOG_WIDTH-1:0] THRESHOLD;
	logic        TX_REQ, TX_ACK, TX_SUCC, TX_FAIL;
	logic        RX_REQ, RX_ACK, RX_BROADCAST;
	logic        LRC_SLEEP, LRC_CLKENB, LRC_RESET, LRC_ISOLATE;
	logic        EXTERNAL_INT, CLR_EXT_INT, SLEEP_REQUEST_TO_SLEEP_CTRL;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	string       t_name  [N_ENTRY];
	logic [7:0]  t_addr  [N_ENTRY];
	logic [31:0] t_data  [N_ENTRY];
	logic [19:0] t_thr   [N_ENTRY];
	bit          t_ring  [N_ENTRY];                       // Ring intact.
	bit          t_succ  [N_ENTRY];                       // TX_SUCC expected, not TX_FAIL.
	bit          t_rx    [N_ENTRY];                       // Delivered to the layer.
	bit          t_sleep [N_ENTRY];                       // Sleep and wake follow.
	bit          t_hold  [N_ENTRY];                       // Layer withholds RX_ACK.

	integer      seed = 77;
	int          value_errs = 0;
	int          event_errs = 0;
	bit          ring_ok;
	bit          hold_ack;
	int          succ_total, fail_total, rx_total;        // Monitor counts.
	int          clk_falls;                               // CLKOUT falling edges.
	logic        clkout_q;
	logic [7:0]  rx_addr_got;
	logic [31:0] rx_data_got;
	logic        rx_bc_got;
	logic        rx_req_q;
	logic        req_now;
	int          rx_age;

	assign DIN = ring_ok ? DOUT : 1'b1;                   // Ring wire or a stuck-high line.

	always #10 CLK_EXT = ~CLK_EXT;                        // 20 ns period.

	mbus_ctrl_wrapper i_dut (.*);

	// Monitor sampling on the falling edge.
	initial
	begin
		succ_total = 0;
		fail_total = 0;
		rx_total   = 0;
		clk_falls  = 0;
		rx_req_q   = 1'b0;
		clkout_q   = 1'b1;
		forever
		begin
			@(negedge CLK_EXT);
			if (TX_SUCC)
				succ_total++;
			if (TX_FAIL)
				fail_total++;
			if (clkout_q && !CLKOUT)
				clk_falls++;                              // Bus clock fell.
			clkout_q = CLKOUT;
			if (RX_REQ && !rx_req_q)
			begin
				rx_total++;                               // New delivery.
				rx_addr_got = RX_ADDR;
				rx_data_got = RX_DATA;
				rx_bc_got   = RX_BROADCAST;
			end
			rx_req_q = RX_REQ;
		end
	end

	// Layer side of the receive handshake.
	initial
	begin
		RX_ACK = 1'b0;
		rx_age = 0;
		forever
		begin
			@(negedge CLK_EXT);
			req_now = RX_REQ;
			if (!req_now)
				rx_age = 0;
			else if (!hold_ack)
				rx_age++;
			@(posedge CLK_EXT);
			#1;
			RX_ACK = req_now && (rx_age >= ACK_DELAY);   // Drops once RX_REQ is low.
		end
	end

	task automatic next_sample();
		@(negedge CLK_EXT);
		#1;
	endtask

	task automatic next_drive();
		@(posedge CLK_EXT);
		#1;
	endtask

	task automatic check_value(input string name, input string what,
		input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp)
		else
		begin
			$display("error %s %s: expected %h, actual %h", name, what, exp, got);
			value_errs++;
		end
	endtask

	task automatic note_failure(input string name, input string msg);
		$display("%s: %s", name, msg);
		event_errs++;
	endtask

	function automatic bit delivery_settled(input int base, input bit held);
		return (rx_total != base) && (held || (!RX_REQ && !RX_ACK));
	endfunction

	task automatic add_entry(input int i, input string name, input logic [7:0] addr,
		input logic [31:0] data, input bit ring, input logic [19:0] thr,
		input bit succ, input bit rx, input bit slp, input bit hold);
		t_name[i]  = name;
		t_addr[i]  = addr;
		t_data[i]  = data;
		t_ring[i]  = ring;
		t_thr[i]   = thr;
		t_succ[i]  = succ;
		t_rx[i]    = rx;
		t_sleep[i] = slp;
		t_hold[i]  = hold;
	endtask

	task automatic build_table();
		add_entry(0, "unicast_p1",  8'h13, $random(seed), 1, 20'd1000, 1, 1, 0, 0);
		add_entry(1, "bcast_func5", 8'h05, $random(seed), 1, 20'd1000, 1, 1, 0, 0);
		add_entry(2, "unicast_p2",  8'h23, $random(seed), 1, 20'd1000, 1, 0, 0, 0);
		add_entry(3, "ctrl_sleep",  8'h00, 32'h1,         1, 20'd1000, 1, 0, 1, 0);
		add_entry(4, "broken_ring", 8'h13, $random(seed), 0, 20'd200,  0, 0, 0, 0);
		add_entry(5, "recover",     8'h17, $random(seed), 1, 20'd1000, 1, 1, 0, 0);
		add_entry(6, "stall_rx",    8'h1a, $random(seed), 1, 20'd1000, 1, 1, 0, 1);
		add_entry(7, "after_stall", 8'h1c, $random(seed), 1, 20'd1000, 1, 1, 0, 0);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sleep and wake sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_sleep_wake(input string name);
		int n;
		int t_iso = -1;
		int t_rst = -1;
		int t_clk = -1;
		int t_slp = -1;
		bit clr_seen = 0;
		for (n = 0; n < PWR_LIMIT && !LRC_SLEEP; n++)
		begin
			next_sample();
			if (LRC_ISOLATE && t_iso < 0)
				t_iso = n;                                // First cycle each is seen.
			if (LRC_RESET && t_rst < 0)
				t_rst = n;
			if (LRC_CLKENB && t_clk < 0)
				t_clk = n;
			if (LRC_SLEEP && t_slp < 0)
				t_slp = n;
		end
		assert (LRC_SLEEP) else note_failure(name, "timed out waiting for LRC_SLEEP");
		assert (t_iso >= 0 && t_iso < t_rst && t_rst < t_clk && t_clk < t_slp)
		else note_failure(name, "LRC outputs did not rise as isolate, reset, clock, sleep");
		for (n = 0; n < PWR_LIMIT && !SLEEP_REQUEST_TO_SLEEP_CTRL; n++)
			next_sample();
		assert (SLEEP_REQUEST_TO_SLEEP_CTRL)
		else note_failure(name, "sleep request never reached the sleep controller");
		next_drive();
		EXTERNAL_INT = 1'b1;                              // One-cycle wake pulse.
		next_drive();
		EXTERNAL_INT = 1'b0;
		for (n = 0; n < PWR_LIMIT && !(clr_seen && !LRC_ISOLATE); n++)
		begin
			next_sample();
			if (CLR_EXT_INT)
				clr_seen = 1;
		end
		assert (clr_seen) else note_failure(name, "CLR_EXT_INT never pulsed after wake");
		check_value(name, "LRC and sleep request after wake", 32'h0,
			{LRC_SLEEP, LRC_CLKENB, LRC_RESET, LRC_ISOLATE, SLEEP_REQUEST_TO_SLEEP_CTRL});
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One table entry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic run_entry(input int i);
		int n;
		int acks = 0;
		int succ_base = succ_total;
		int fail_base = fail_total;
		int rx_base   = rx_total;
		int fall_base = clk_falls;
		next_drive();
		ring_ok   = t_ring[i];
		THRESHOLD = t_thr[i];
		TX_ADDR   = t_addr[i];
		TX_DATA   = t_data[i];
		TX_REQ    = 1'b1;
		if (t_hold[i])
			hold_ack = 1'b1;                              // Next delivery goes unanswered.
		if (i > 0 && t_hold[i-1])
		begin
			repeat (STALL_CYCLES)
			begin
				next_sample();
				if (TX_ACK)
					acks++;
			end
			check_value(t_name[i], "TX_ACK under back-pressure", 32'd0, acks);
			next_drive();
			hold_ack = 1'b0;                              // Layer catches up.
		end
		for (n = 0; n < ACK_LIMIT && !TX_ACK; n++)
			next_sample();
		assert (TX_ACK) else note_failure(t_name[i], "timed out waiting for TX_ACK");
		next_drive();
		TX_REQ = 1'b0;
		for (n = 0; n < DONE_LIMIT && succ_total + fail_total == succ_base + fail_base; n++)
			next_sample();
		assert (succ_total + fail_total != succ_base + fail_base)
		else note_failure(t_name[i], "timed out waiting for TX_SUCC or TX_FAIL");
		if (t_sleep[i])
			check_sleep_wake(t_name[i]);
		if (t_rx[i])
		begin
			for (n = 0; n < RX_LIMIT && !delivery_settled(rx_base, t_hold[i]); n++)
				next_sample();
			assert (delivery_settled(rx_base, t_hold[i]))
			else note_failure(t_name[i], "receive handshake did not complete");
		end
		else
			repeat (RX_LIMIT) next_sample();              // Nothing may arrive.
		// Exactly one result pulse over the whole entry.
		check_value(t_name[i], "TX_SUCC pulses", t_succ[i], succ_total - succ_base);
		check_value(t_name[i], "TX_FAIL pulses", !t_succ[i], fail_total - fail_base);
		if (t_succ[i])
			check_value(t_name[i], "CLKOUT falling edges",
				1 + mbus_bus_pkg::ADDR_WIDTH + mbus_bus_pkg::DATA_WIDTH,
				clk_falls - fall_base);                   // One bus clock per frame bit.
		check_value(t_name[i], "deliveries", t_rx[i], rx_total - rx_base);
		if (t_rx[i] && rx_total != rx_base)
		begin
			check_value(t_name[i], "RX_ADDR", t_addr[i], rx_addr_got);
			check_value(t_name[i], "RX_DATA", t_data[i], rx_data_got);
			check_value(t_name[i], "RX_BROADCAST", t_addr[i][7:4] == 4'h0, rx_bc_got);
		end
	endtask

	initial
	begin
		RESETn_local = 1'b0;
		TX_REQ       = 1'b0;
		TX_ADDR      = '0;
		TX_DATA      = '0;
		THRESHOLD    = '0;
		EXTERNAL_INT = 1'b0;
		ring_ok      = 1'b1;
		hold_ack     = 1'b0;
		build_table();
		repeat (16) @(posedge CLK_EXT);
		#1;
		// Idle values while still in reset.
		check_value("reset", "idle outputs", 32'h0c0,
			{TX_ACK, TX_SUCC, TX_FAIL, RX_REQ, CLKOUT, DOUT, LRC_SLEEP, LRC_CLKENB,
			LRC_RESET, LRC_ISOLATE, SLEEP_REQUEST_TO_SLEEP_CTRL, CLR_EXT_INT});
		RESETn_local = 1'b1;
		for (int i = 0; i < N_ENTRY; i++)
			run_entry(i);
		$display("checks failed: %0d wrong values, %0d other failures", value_errs, event_errs);
		if (value_errs == 0 && event_errs == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: logic/mbus_ctrl_wrapper.sv
`timescale 1ns/10ps

module mbus_ctrl_wrapper (
	input  logic                                      CLK_EXT,
	input  logic                                      RESETn_local,
	input  logic                                      DIN,
	output logic                                      DOUT,
	output logic                                      CLKOUT,
	input  logic [mbus_bus_pkg::ADDR_WIDTH-1:0]       TX_ADDR,
	input  logic [mbus_bus_pkg::DATA_WIDTH-1:0]       TX_DATA,
	input  logic                                      TX_REQ,
	output logic                                      TX_ACK,
	output logic                                      TX_SUCC,
	output logic                                      TX_FAIL,
	output logic [mbus_bus_pkg::ADDR_WIDTH-1:0]       RX_ADDR,
	output logic [mbus_bus_pkg::DATA_WIDTH-1:0]       RX_DATA,
	output logic                                      RX_REQ,
	input  logic                                      RX_ACK,
	output logic                                      RX_BROADCAST,
	input  logic [mbus_bus_pkg::WATCH_DOG_WIDTH-1:0]  THRESHOLD,
	output logic                                      LRC_SLEEP,
	output logic                                      LRC_CLKENB,
	output logic                                      LRC_RESET,
	output logic                                      LRC_ISOLATE,
	input  logic                                      EXTERNAL_INT,
	output logic                                      CLR_EXT_INT,
	output logic                                      SLEEP_REQUEST_TO_SLEEP_CTRL
);

	logic tx_start;
	logic frame_done;
	logic bit_strobe;
	logic bus_abort;
	logic node_rx_req;
	logic node_rx_ack;
	logic sleep_req;
	logic ctrl_addr_match;                                // Control broadcast pending.
	logic ctrl_rx_ack;                                    // Internal acknowledge.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control channel filter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign ctrl_addr_match = RX_BROADCAST &
		(RX_ADDR[mbus_bus_pkg::FUNC_WIDTH-1:0] == mbus_bus_pkg::CHANNEL_CTRL);
	assign RX_REQ      = node_rx_req & ~ctrl_addr_match;   // Hidden from the layer.
	assign node_rx_ack = RX_ACK | ctrl_rx_ack;

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			ctrl_rx_ack                 <= 1'b0;
			SLEEP_REQUEST_TO_SLEEP_CTRL <= 1'b0;
		end
		else
		begin
			if (ctrl_addr_match && node_rx_req)
				ctrl_rx_ack <= 1'b1;                      // Ack on the layer's behalf.
			else if (!node_rx_req)
				ctrl_rx_ack <= 1'b0;                      // Node dropped its request.
			SLEEP_REQUEST_TO_SLEEP_CTRL <= sleep_req;     // One cycle late.
		end
	end

	mbus_ctrl ctrl0 (
		.CLK_EXT      (CLK_EXT),
		.RESETn_local (RESETn_local),
		.tx_start     (tx_start),
		.frame_done   (frame_done),
		.THRESHOLD    (THRESHOLD),
		.CLKOUT       (CLKOUT),
		.bit_strobe   (bit_strobe),
		.bus_abort    (bus_abort)
	);

	mbus_node node0 (
		.CLK_EXT      (CLK_EXT),
		.RESETn_local (RESETn_local),
		.DIN          (DIN),
		.TX_ADDR      (TX_ADDR),
		.TX_DATA      (TX_DATA),
		.TX_REQ       (TX_REQ),
		.node_rx_ack  (node_rx_ack),
		.bit_strobe   (bit_strobe),
		.bus_abort    (bus_abort),
		.EXTERNAL_INT (EXTERNAL_INT),
		.DOUT         (DOUT),
		.TX_ACK       (TX_ACK),
		.TX_SUCC      (TX_SUCC),
		.TX_FAIL      (TX_FAIL),
		.tx_start     (tx_start),
		.frame_done   (frame_done),
		.RX_ADDR      (RX_ADDR),
		.RX_DATA      (RX_DATA),
		.RX_BROADCAST (RX_BROADCAST),
		.node_rx_req  (node_rx_req),
		.sleep_req    (sleep_req),
		.LRC_SLEEP    (LRC_SLEEP),
		.LRC_CLKENB   (LRC_CLKENB),
		.LRC_RESET    (LRC_RESET),
		.LRC_ISOLATE  (LRC_ISOLATE),
		.CLR_EXT_INT  (CLR_EXT_INT)
	);

endmodule

// File: logic/mbus_node.sv
`timescale 1ns/10ps

module mbus_node (
	input  logic                                 CLK_EXT,
	input  logic                                 RESETn_local,
	input  logic                                 DIN,
	input  logic [mbus_bus_pkg::ADDR_WIDTH-1:0]  TX_ADDR,
	input  logic [mbus_bus_pkg::DATA_WIDTH-1:0]  TX_DATA,
	input  logic                                 TX_REQ,
	input  logic                                 node_rx_ack,
	input  logic                                 bit_strobe,
	input  logic                                 bus_abort,
	input  logic                                 EXTERNAL_INT,
	output logic                                 DOUT,
	output logic                                 TX_ACK,
	output logic                                 TX_SUCC,
	output logic                                 TX_FAIL,
	output logic                                 tx_start,
	output logic                                 frame_done,
	output logic [mbus_bus_pkg::ADDR_WIDTH-1:0]  RX_ADDR,
	output logic [mbus_bus_pkg::DATA_WIDTH-1:0]  RX_DATA,
	output logic                                 RX_BROADCAST,
	output logic                                 node_rx_req,
	output logic                                 sleep_req,
	output logic                                 LRC_SLEEP,
	output logic                                 LRC_CLKENB,
	output logic                                 LRC_RESET,
	output logic                                 LRC_ISOLATE,
	output logic                                 CLR_EXT_INT
);

	logic                                       tx_busy;   // Own frame outstanding.
	logic [mbus_bus_pkg::FRAME_BITS-1:0]        tx_shift;  // MSB drives DOUT.
	logic                                       rx_active; // Start bit seen.
	logic [$clog2(mbus_bus_pkg::FRAME_BITS)-1:0] rx_cnt;   // Payload bits taken.
	logic [mbus_bus_pkg::FRAME_BITS-2:0]        rx_shift;  // Address and data.
	logic                                       rx_match;
	logic                                       rx_ctrl;
	logic                                       rx_wait;   // Frame held for ack low.
	logic                                       sleep_cmd;
	mbus_power_pkg::power_state_t               pwr_state;

	assign DOUT         = tx_shift[mbus_bus_pkg::FRAME_BITS-1];
	assign RX_ADDR      = rx_shift[mbus_bus_pkg::FRAME_BITS-2 -: mbus_bus_pkg::ADDR_WIDTH];
	assign RX_DATA      = rx_shift[mbus_bus_pkg::DATA_WIDTH-1:0];
	assign RX_BROADCAST = RX_ADDR[mbus_bus_pkg::ADDR_WIDTH-1 -: mbus_bus_pkg::PREFIX_WIDTH]
		== mbus_bus_pkg::BROADCAST_PREFIX;
	assign rx_match     = RX_BROADCAST | (RX_ADDR[mbus_bus_pkg::ADDR_WIDTH-1 -:
		mbus_bus_pkg::PREFIX_WIDTH] == mbus_bus_pkg::NODE_PREFIX); // Ours or everyone's.
	assign rx_ctrl      = RX_BROADCAST &
		(RX_ADDR[mbus_bus_pkg::FUNC_WIDTH-1:0] == mbus_bus_pkg::CHANNEL_CTRL);
	assign sleep_req    = pwr_state == mbus_power_pkg::ASLEEP;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Transmit side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			TX_ACK   <= 1'b0;
			TX_SUCC  <= 1'b0;
			TX_FAIL  <= 1'b0;
			tx_start <= 1'b0;
			tx_busy  <= 1'b0;
			tx_shift <= '1;                               // DOUT idles high.
		end
		else
		begin
			tx_start <= 1'b0;
			TX_SUCC  <= 1'b0;
			TX_FAIL  <= 1'b0;
			if (TX_REQ && !TX_ACK && !tx_busy && !node_rx_req && !rx_wait)
			begin
				TX_ACK   <= 1'b1;                         // Accept the frame.
				tx_start <= 1'b1;
				tx_busy  <= 1'b1;
				tx_shift <= {1'b0, TX_ADDR, TX_DATA};     // Start bit first.
			end
			else if (TX_ACK && !TX_REQ)
				TX_ACK <= 1'b0;                           // Close the handshake.
			if (tx_busy && frame_done)
			begin
				TX_SUCC <= 1'b1;                          // Frame came round.
				tx_busy <= 1'b0;
			end
			else if (tx_busy && bus_abort)
			begin
				TX_FAIL  <= 1'b1;                         // Watchdog gave up.
				tx_busy  <= 1'b0;
				tx_shift <= '1;
			end
			else if (bit_strobe)
				tx_shift <= {tx_shift[mbus_bus_pkg::FRAME_BITS-2:0], 1'b1};
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Receive side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK_EXT)
	begin
		if (bit_strobe && rx_active && !bus_abort)
			rx_shift <= {rx_shift[mbus_bus_pkg::FRAME_BITS-3:0], DIN}; // MSB first.
	end

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			rx_active   <= 1'b0;
			rx_cnt      <= '0;
			frame_done  <= 1'b0;
			node_rx_req <= 1'b0;
			rx_wait     <= 1'b0;
			sleep_cmd   <= 1'b0;
		end
		else
		begin
			frame_done <= 1'b0;
			sleep_cmd  <= 1'b0;
			if (bus_abort)
				rx_active <= 1'b0;                        // Drop a partial frame.
			else if (bit_strobe && rx_active)
			begin
				rx_cnt <= rx_cnt + 1'b1;
				if (rx_cnt == ($clog2(mbus_bus_pkg::FRAME_BITS))'(mbus_bus_pkg::FRAME_BITS - 2))
				begin
					rx_active  <= 1'b0;                   // Last bit in.
					frame_done <= 1'b1;
				end
			end
			else if (bit_strobe && !DIN)
			begin
				rx_active <= 1'b1;                        // Start bit.
				rx_cnt    <= '0;
			end
			// Delivery handshake toward the layer.
			if (node_rx_req && node_rx_ack)
			begin
				node_rx_req <= 1'b0;
				sleep_cmd   <= rx_ctrl & (RX_DATA[mbus_power_pkg::CMD_WIDTH-1:0]
					== mbus_power_pkg::CMD_SLEEP);
			end
			else if ((rx_wait || (frame_done && rx_match)) && !node_rx_ack)
			begin
				node_rx_req <= 1'b1;
				rx_wait     <= 1'b0;
			end
			else if (frame_done && rx_match)
				rx_wait <= 1'b1;                          // Previous ack still high.
		end
	end

	mbus_power_seq pwr0 (
		.CLK_EXT      (CLK_EXT),
		.RESETn_local (RESETn_local),
		.sleep_cmd    (sleep_cmd),
		.EXTERNAL_INT (EXTERNAL_INT),
		.LRC_SLEEP    (LRC_SLEEP),
		.LRC_CLKENB   (LRC_CLKENB),
		.LRC_RESET    (LRC_RESET),
		.LRC_ISOLATE  (LRC_ISOLATE),
		.CLR_EXT_INT  (CLR_EXT_INT),
		.state        (pwr_state)
	);

endmodule

// File: logic/mbus_power_seq.sv
`timescale 1ns/10ps

module mbus_power_seq (
	input  logic                         CLK_EXT,
	input  logic                         RESETn_local,
	input  logic                         sleep_cmd,
	input  logic                         EXTERNAL_INT,
	output logic                         LRC_SLEEP,
	output logic                         LRC_CLKENB,
	output logic                         LRC_RESET,
	output logic                         LRC_ISOLATE,
	output logic                         CLR_EXT_INT,
	output mbus_power_pkg::power_state_t state
);

	mbus_power_pkg::power_state_t state_nxt;
	logic                         waking;             // Walking the wake order.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		state_nxt = state;
		case (state)
			mbus_power_pkg::AWAKE:
				if (sleep_cmd)
					state_nxt = mbus_power_pkg::ISOLATING;            // Isolate first.
			mbus_power_pkg::ISOLATING:
				state_nxt = waking ? mbus_power_pkg::AWAKE : mbus_power_pkg::RESETTING;
			mbus_power_pkg::RESETTING:
				state_nxt = waking ? mbus_power_pkg::ISOLATING : mbus_power_pkg::GATING;
			mbus_power_pkg::GATING:
				state_nxt = mbus_power_pkg::ASLEEP;
			mbus_power_pkg::ASLEEP:
				if (EXTERNAL_INT)
					state_nxt = mbus_power_pkg::UNGATING;             // Sleep released first.
			mbus_power_pkg::UNGATING:
				state_nxt = mbus_power_pkg::RESETTING;                // Then the clock.
			default:
				state_nxt = mbus_power_pkg::AWAKE;
		endcase
	end

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			state       <= mbus_power_pkg::AWAKE;
			waking      <= 1'b0;
			LRC_ISOLATE <= 1'b0;
			LRC_RESET   <= 1'b0;
			LRC_CLKENB  <= 1'b0;
			LRC_SLEEP   <= 1'b0;
			CLR_EXT_INT <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if (state == mbus_power_pkg::ASLEEP && EXTERNAL_INT)
				waking <= 1'b1;                           // Reverse direction.
			else if (state_nxt == mbus_power_pkg::AWAKE)
				waking <= 1'b0;
			// Outputs follow the state they enter.
			LRC_ISOLATE <= state_nxt != mbus_power_pkg::AWAKE;
			LRC_RESET   <= state_nxt inside {mbus_power_pkg::RESETTING, mbus_power_pkg::GATING,
				mbus_power_pkg::ASLEEP, mbus_power_pkg::UNGATING};
			LRC_CLKENB  <= state_nxt inside {mbus_power_pkg::GATING, mbus_power_pkg::ASLEEP,
				mbus_power_pkg::UNGATING};
			LRC_SLEEP   <= state_nxt == mbus_power_pkg::ASLEEP;
			// Clear the interrupt once fully awake.
			CLR_EXT_INT <= waking & (state_nxt == mbus_power_pkg::AWAKE);
		end
	end

endmodule

// File: logic/mbus_ctrl.sv
`timescale 1ns/10ps

module mbus_ctrl (
	input  logic                                      CLK_EXT,
	input  logic                                      RESETn_local,
	input  logic                                      tx_start,
	input  logic                                      frame_done,
	input  logic [mbus_bus_pkg::WATCH_DOG_WIDTH-1:0]  THRESHOLD,
	output logic                                      CLKOUT,
	output logic                                      bit_strobe,
	output logic                                      bus_abort
);

	logic                                     busy;      // Frame on the ring.
	logic [mbus_bus_pkg::WATCH_DOG_WIDTH-1:0] wd_cnt;    // Busy cycles so far.
	logic                                     abort_hit; // Watchdog expiry.

	assign abort_hit = busy & (wd_cnt == THRESHOLD);      // Count reached the limit.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus activity and abort
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			busy      <= 1'b0;
			bus_abort <= 1'b0;
		end
		else
		begin
			bus_abort <= abort_hit;                       // One pulse, busy drops with it.
			if (frame_done || abort_hit)
				busy <= 1'b0;                             // Frame back or given up.
			else if (tx_start)
				busy <= 1'b1;                             // Node started a frame.
		end
	end

	// Bus clock, idles high, one bit per full period.
	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			CLKOUT     <= 1'b1;
			bit_strobe <= 1'b0;
		end
		else
		begin
			// Strobe lands on each falling edge of CLKOUT.
			bit_strobe <= busy & CLKOUT & ~frame_done & ~abort_hit;
			if (busy && !frame_done && !abort_hit)
				CLKOUT <= ~CLKOUT;                        // Toggle every cycle.
			else
				CLKOUT <= 1'b1;                           // Park high when idle.
		end
	end

	// Watchdog counter.
	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
			wd_cnt <= '0;
		else if (busy)
			wd_cnt <= wd_cnt + 1'b1;                      // Count busy cycles.
		else
			wd_cnt <= '0;                                 // Cleared at idle.
	end

endmodule

// File: logic/mbus_power_pkg.sv
package mbus_power_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Layer power sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [2:0] {
		AWAKE,                                            // All signals released.
		ISOLATING,                                        // Isolation only.
		RESETTING,                                        // Isolated, held in reset.
		GATING,                                           // Clock gated as well.
		ASLEEP,                                           // Power gated.
		UNGATING                                          // Power back, clock still off.
	} power_state_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control channel commands
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int CMD_WIDTH = 4;                         // Data bits 3:0.
	localparam logic [CMD_WIDTH-1:0] CMD_SLEEP = 4'd1;    // Put the layer to sleep.

endpackage

// File: logic/mbus_bus_pkg.sv
package mbus_bus_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Frame geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int ADDR_WIDTH = 8;                        // Address bits per frame.
	localparam int DATA_WIDTH = 32;                       // Data bits per frame.
	localparam int FRAME_BITS = 1 + ADDR_WIDTH + DATA_WIDTH; // Start bit included.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address fields
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int FUNC_WIDTH   = 4;                      // Low nibble, function.
	localparam int PREFIX_WIDTH = 4;                      // High nibble, destination.

	// Prefix 0 reaches every node on the ring.
	localparam logic [PREFIX_WIDTH-1:0] BROADCAST_PREFIX = 4'h0;
	localparam logic [PREFIX_WIDTH-1:0] NODE_PREFIX      = 4'h1; // Our own prefix.

	// Broadcast function reserved for bus control.
	localparam logic [FUNC_WIDTH-1:0] CHANNEL_CTRL = 4'h0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Watchdog
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int WATCH_DOG_WIDTH = 20;                  // THRESHOLD and counter.

endpackage
